/* hw/pcm_dac.sv */
module pcm_dac
  import upd1771_snd_pkg::*;
(
  input  logic    CLK,
  input  logic    arst_n,
  input  logic    da_wr,
  input  sample_t da_data,
  input  logic    ss,
  input  logic    ts,
  output pcm_t    pcm_out
);

  ////////////////////
  // DA register
  ////////////////////

  // bit 9 inverts the sample and bit 8 is the negative flag
  logic [9:0] da;
  sample_t    magnitude;
  logic       negative;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      da <= '0;
    end else if (da_wr) begin
      da <= {ss ^ ts, ss, da_data};
    end
  end

  ////////////////////
  // conversion
  ////////////////////

  assign negative = da[8];

  always_comb begin
    if (da[9]) begin
      magnitude = ~da[7:0];  // inverted sample
    end else begin
      magnitude = da[7:0];
    end
  end

  // 9-bit two's complement with the sign on top
  assign pcm_out = {negative, negative ? ~magnitude : magnitude};

endmodule

/* hw/tone_counter.sv */
module tone_counter
  import upd1771_snd_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      n_wr,
  input  tone_n_t   n_data,
  output logic      tick,
  output logic      nc_reload,
  output tone_nuc_t nuc,
  output n_range_e  n_range
);

  localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_DIV - 1);

  logic [TICK_CNT_W-1:0] tb_cnt;  // machine cycle phase
  tone_n_t               n_reg;   // reload value N
  tone_n_t               nc;      // down-counter NC
  logic                  reload_d;

  ////////////////////
  // timebase
  ////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tb_cnt <= '0;
    end else if (tick) begin
      tb_cnt <= '0;
    end else begin
      tb_cnt <= tb_cnt + 1'b1;
    end
  end

  assign tick = (tb_cnt == TICK_LAST);  // one CLK in every TICK_DIV

  ////////////////////
  // tone counter
  ////////////////////

  assign nc_reload = tick & (nc == 8'd1);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      n_reg <= '0;
    end else if (n_wr) begin
      n_reg <= n_data;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      nc       <= '0;
      nuc      <= '0;
      reload_d <= 1'b0;
    end else if (tick) begin
      if (nc_reload) begin
        nc <= n_reg;
      end else begin
        nc <= nc - 1'b1;  // 0x00 wraps to 0xff
      end
      reload_d <= nc_reload;
      if (reload_d) begin
        nuc <= nuc + 1'b1;  // one tick behind the reload
      end
    end
  end

  // decode N once for the interrupt stage
  always_comb begin
    if (n_reg[7:6] != 2'b00) begin
      n_range = RANGE_40;
    end else if (n_reg[5]) begin
      n_range = RANGE_20;
    end else if (n_reg[4]) begin
      n_range = RANGE_10;
    end else if (n_reg[3]) begin
      n_range = RANGE_08;
    end else begin
      n_range = RANGE_OFF;
    end
  end

endmodule

/* hw/tone_irq.sv */
module tone_irq
  import upd1771_snd_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      tick,
  input  logic      nc_reload,
  input  tone_nuc_t nuc,
  input  n_range_e  n_range,
  input  logic      tone_ie,
  input  logic      int_ack,
  output logic      irq_load,
  output int_vec_t  int_vec,
  output logic      irq_active
);

  logic       cond;      // selected tone condition
  logic       cond_d;    // condition at the previous tick
  logic       reload_d;  // reload flag, one tick late
  logic       trigger;
  irq_state_e state;
  irq_state_e state_nxt;
  int_vec_t   vec_sel;
  int_vec_t   vec_q;

  ////////////////////
  // condition and edge
  ////////////////////

  always_comb begin
    case (n_range)
      RANGE_08: cond = nuc[2];
      RANGE_10: cond = nuc[1];
      RANGE_20: cond = nuc[0];
      RANGE_40: cond = reload_d;
      default:  cond = 1'b0;  // N below 8 never interrupts
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cond_d   <= 1'b0;
      reload_d <= 1'b0;
    end else if (tick) begin
      cond_d   <= cond;
      reload_d <= nc_reload;
    end
  end

  // falling edge between two ticks
  assign trigger = tick & cond_d & ~cond;

  ////////////////////
  // interrupt FSM
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IRQ_IDLE: begin
        if (trigger && tone_ie) begin
          state_nxt = IRQ_PENDING;
        end
      end
      IRQ_PENDING: begin
        if (tick) begin
          state_nxt = IRQ_ACTIVE;
        end
      end
      IRQ_ACTIVE: begin
        if (int_ack) begin
          state_nxt = IRQ_IDLE;  // RETI ends the interrupt
        end
      end
      default: state_nxt = IRQ_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= IRQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign irq_load   = (state == IRQ_PENDING) & tick;
  assign irq_active = (state == IRQ_ACTIVE);

  // vector follows the range at the moment of the load
  always_comb begin
    case (n_range)
      RANGE_10: vec_sel = TONE_VEC_BASE + TONE_VEC_STEP;
      RANGE_20: vec_sel = TONE_VEC_BASE + (TONE_VEC_STEP << 1);
      RANGE_40: vec_sel = TONE_VEC_BASE + TONE_VEC_STEP + (TONE_VEC_STEP << 1);
      default:  vec_sel = TONE_VEC_BASE;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      vec_q <= '0;
    end else if (irq_load) begin
      vec_q <= vec_sel;
    end
  end

  assign int_vec = irq_load ? vec_sel : vec_q;  // held until the next load

endmodule

/* hw/upd1771_snd.sv */
module upd1771_snd
  import upd1771_snd_pkg::*;
(
  input  logic     CLK,
  input  logic     arst_n,
  // tone control
  input  logic     n_wr,
  input  tone_n_t  n_data,
  input  logic     tone_ie,
  // DAC write
  input  logic     da_wr,
  input  sample_t  da_data,
  input  logic     ss,
  input  logic     ts,
  // interrupt
  input  logic     int_ack,
  output logic     irq_load,
  output int_vec_t int_vec,
  output logic     irq_active,
  // sound out
  output pcm_t     pcm_out
);

  logic      tick;
  logic      nc_reload;
  tone_nuc_t nuc;
  n_range_e  n_range;

  tone_counter tone_counter_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .n_wr      (n_wr),
    .n_data    (n_data),
    .tick      (tick),
    .nc_reload (nc_reload),
    .nuc       (nuc),
    .n_range   (n_range)
  );

  tone_irq tone_irq_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .tick       (tick),
    .nc_reload  (nc_reload),
    .nuc        (nuc),
    .n_range    (n_range),
    .tone_ie    (tone_ie),
    .int_ack    (int_ack),
    .irq_load   (irq_load),
    .int_vec    (int_vec),
    .irq_active (irq_active)
  );

  pcm_dac pcm_dac_i (  // independent output stage
    .CLK     (CLK),
    .arst_n  (arst_n),
    .da_wr   (da_wr),
    .da_data (da_data),
    .ss      (ss),
    .ts      (ts),
    .pcm_out (pcm_out)
  );

endmodule

/* hw/upd1771_snd_pkg.sv */
package upd1771_snd_pkg;

  ////////////////////
  // timebase
  ////////////////////

  localparam int unsigned TICK_DIV   = 8;                 // CLK cycles per machine tick
  localparam int unsigned TICK_CNT_W = $clog2(TICK_DIV);  // timebase counter width

  ////////////////////
  // data widths
  ////////////////////

  typedef logic [7:0]  tone_n_t;    // N reload value and NC count
  typedef logic [2:0]  tone_nuc_t;  // NC reload counter
  typedef logic [7:0]  sample_t;    // raw DAC sample
  typedef logic [8:0]  pcm_t;       // two's complement PCM
  typedef logic [11:0] int_vec_t;   // program address of a vector

  ////////////////////
  // state encodings
  ////////////////////

  // N decoded into the ranges that pick the tone interrupt source
  typedef enum logic [2:0] {
    RANGE_OFF = 3'd0,  // 0x00..0x07 gives no interrupt
    RANGE_08  = 3'd1,  // 0x08..0x0f
    RANGE_10  = 3'd2,  // 0x10..0x1f
    RANGE_20  = 3'd3,  // 0x20..0x3f
    RANGE_40  = 3'd4   // 0x40..0xff
  } n_range_e;

  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'd0,
    IRQ_PENDING = 2'd1,
    IRQ_ACTIVE  = 2'd2
  } irq_state_e;

  localparam int_vec_t TONE_VEC_BASE = 12'h020;  // vector for RANGE_08
  localparam int_vec_t TONE_VEC_STEP = 12'h004;  // added per range above

endpackage

/* project.f */
hw/upd1771_snd_pkg.sv
hw/tone_counter.sv
hw/tone_irq.sv
hw/pcm_dac.sv
hw/upd1771_snd.sv
tests/upd1771_snd_props.sv
tests/tb_upd1771_snd.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module tb_upd1771_snd \
  -f project.f \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
exit 1

/* tests/tb_upd1771_snd.sv */
module tb_upd1771_snd;

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // run limits
  ////////////////////

  localparam int LEN_RESET  = 60;
  localparam int LEN_DAC    = 800;
  localparam int LEN_VEC    = 33000;  // 4 ranges with 2 loads each
  localparam int LEN_PERIOD = 16500;
  localparam int LEN_QUIET  = 5000;
  localparam int LEN_SINGLE = 10700;
  localparam int LEN_SUM    = LEN_RESET + LEN_DAC + LEN_VEC + LEN_PERIOD + LEN_QUIET + LEN_SINGLE;
  localparam int CYC_LIMIT  = LEN_SUM + LEN_SUM / 10;
  localparam int LOAD_WAIT  = 4096;  // worst first load plus one period

  logic        CLK;
  logic        arst_n;
  logic        n_wr;
  logic [7:0]  n_data;
  logic        tone_ie;
  logic        da_wr;
  logic [7:0]  da_data;
  logic        ss;
  logic        ts;
  logic        int_ack;
  logic        irq_load;
  logic [11:0] int_vec;
  logic        irq_active;
  logic [8:0]  pcm_out;

  integer seed = 73576;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cyc = 0;
  int     load_cnt = 0;
  int     last_load_cyc = 0;
  logic [11:0] last_vec = '0;

  upd1771_snd upd1771_snd_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .n_wr       (n_wr),
    .n_data     (n_data),
    .tone_ie    (tone_ie),
    .da_wr      (da_wr),
    .da_data    (da_data),
    .ss         (ss),
    .ts         (ts),
    .int_ack    (int_ack),
    .irq_load   (irq_load),
    .int_vec    (int_vec),
    .irq_active (irq_active),
    .pcm_out    (pcm_out)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic int range_of(input logic [7:0] n);
    if (n >= 8'h40) return 4;
    if (n >= 8'h20) return 3;
    if (n >= 8'h10) return 2;
    if (n >= 8'h08) return 1;
    return 0;
  endfunction

  function automatic logic [11:0] vec_of(input int rng);
    case (rng)
      2:       return 12'h024;
      3:       return 12'h028;
      4:       return 12'h02c;
      default: return 12'h020;
    endcase
  endfunction

  function automatic logic cond_of(input int rng, input logic [2:0] nuc, input logic rel_d);
    case (rng)
      1:       return nuc[2];
      2:       return nuc[1];
      3:       return nuc[0];
      4:       return rel_d;  // reload one tick late
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [8:0] pcm_of(input logic s_neg, input logic s_tone,
                                        input logic [7:0] smp);
    return {s_neg, s_tone ? ~smp : smp};  // low bits flip with ts alone
  endfunction

  int          m_tb = 0;      // phase 0..7
  logic [7:0]  m_n = '0;
  logic [7:0]  m_nc = '0;
  logic [2:0]  m_nuc = '0;
  logic        m_rel_d = 1'b0;
  logic        m_cond_d = 1'b0;
  int          m_state = 0;   // 0 idle, 1 pending, 2 active
  logic [11:0] m_vec = '0;
  logic        m_ss = 1'b0;
  logic        m_ts = 1'b0;
  logic [7:0]  m_s = '0;

  always @(posedge CLK or negedge arst_n) begin
    logic m_tick;
    logic m_rel;
    logic m_cond;
    logic m_trig;
    int   m_rng;
    if (!arst_n) begin
      m_tb     = 0;
      m_n      = '0;
      m_nc     = '0;
      m_nuc    = '0;
      m_rel_d  = 1'b0;
      m_cond_d = 1'b0;
      m_state  = 0;
      m_vec    = '0;
      m_ss     = 1'b0;
      m_ts     = 1'b0;
      m_s      = '0;
    end else begin
      m_tick = (m_tb == 7);
      m_rel  = m_tick && (m_nc == 8'd1);
      m_rng  = range_of(m_n);
      m_cond = cond_of(m_rng, m_nuc, m_rel_d);
      m_trig = m_tick && m_cond_d && !m_cond;
      if (m_state == 1 && m_tick) m_vec = vec_of(m_rng);
      case (m_state)
        0: if (m_trig && tone_ie) m_state = 1;
        1: if (m_tick) m_state = 2;
        default: if (int_ack) m_state = 0;
      endcase
      if (m_tick) begin
        m_cond_d = m_cond;
        m_nc = m_rel ? m_n : m_nc - 8'd1;
        if (m_rel_d) m_nuc = m_nuc + 3'd1;
        m_rel_d = m_rel;
      end
      if (n_wr) m_n = n_data;
      if (da_wr) begin
        m_ss = ss;
        m_ts = ts;
        m_s  = da_data;
      end
      m_tb = m_tick ? 0 : m_tb + 1;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge CLK) begin
    logic        e_load;
    logic [11:0] e_vec;
    logic        e_active;
    logic [8:0]  e_pcm;
    if (arst_n) begin
      e_load   = (m_state == 1) && (m_tb == 7);
      e_vec    = e_load ? vec_of(range_of(m_n)) : m_vec;
      e_active = (m_state == 2);
      e_pcm    = pcm_of(m_ss, m_ts, m_s);
      assert (irq_load === e_load) else begin
        $display("ERR irq_load exp %h got %h at cycle %0d", e_load, irq_load, cyc);
        errors++;
      end
      assert (int_vec === e_vec) else begin
        $display("ERR int_vec exp %h got %h at cycle %0d", e_vec, int_vec, cyc);
        errors++;
      end
      assert (irq_active === e_active) else begin
        $display("ERR irq_active exp %h got %h at cycle %0d", e_active, irq_active, cyc);
        errors++;
      end
      assert (pcm_out === e_pcm) else begin
        $display("ERR pcm_out exp %h got %h at cycle %0d", e_pcm, pcm_out, cyc);
        errors++;
      end
      if (irq_load === 1'b1) begin
        load_cnt++;
        last_load_cyc = cyc;
        last_vec = int_vec;
      end
    end
  end

  always @(posedge CLK) begin
    cyc++;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic pick_n(input int unsigned lo, input int unsigned hi, output logic [7:0] v);
    int unsigned r;
    r = $random(seed);
    v = 8'(lo + r % (hi - lo + 1));
  endtask

  task automatic write_n(input logic [7:0] v);
    @(posedge CLK);
    n_wr   <= 1'b1;
    n_data <= v;
    @(posedge CLK);
    n_wr   <= 1'b0;
  endtask

  task automatic pulse_ack();
    @(posedge CLK);
    int_ack <= 1'b1;
    @(posedge CLK);
    int_ack <= 1'b0;
  endtask

  task automatic wait_loads(input int target);
    int n;
    n = 0;
    while (load_cnt < target) begin
      @(posedge CLK);
      n++;
      if (n > LOAD_WAIT) begin
        $display("no irq_load number %0d within %0d cycles", target, LOAD_WAIT);
        errors++;
        break;
      end
    end
  endtask

  // leave the interrupt idle before the next test
  task automatic settle_irq();
    @(posedge CLK);
    tone_ie <= 1'b0;
    repeat (16) @(negedge CLK);
    if (irq_active) pulse_ack();
    repeat (2) @(posedge CLK);
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %-10s %s (%0d errors)", name,
             (errors == err_before) ? "pass" : "FAIL", errors - err_before);
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    int          e0;
    int          base;
    logic [7:0]  n;
    logic [31:0] r;
    logic [8:0]  exp_pcm;
    int          t[4];
    logic [11:0] exp_vec[4];
    int unsigned lo[4];
    int unsigned hi[4];
    exp_vec = '{12'h020, 12'h024, 12'h028, 12'h02c};
    lo = '{8, 16, 32, 64};
    hi = '{15, 31, 63, 255};
    arst_n  = 1'b0;
    n_wr    = 1'b0;
    n_data  = '0;
    tone_ie = 1'b0;
    da_wr   = 1'b0;
    da_data = '0;
    ss      = 1'b0;
    ts      = 1'b0;
    int_ack = 1'b0;
    repeat (10) @(posedge CLK);
    arst_n <= 1'b1;

    e0 = errors;  // reset values
    repeat (20) begin
      @(negedge CLK);
      assert (irq_active === 1'b0 && irq_load === 1'b0 && pcm_out === 9'h000) else begin
        $display("ERR reset outputs exp 0 got active %h load %h pcm %h",
                 irq_active, irq_load, pcm_out);
        errors++;
      end
    end
    report("reset", e0);

    e0 = errors;
    repeat (300) begin
      r = $random(seed);
      @(posedge CLK);
      da_wr   <= 1'b1;
      da_data <= r[7:0];
      ss      <= r[8];
      ts      <= r[9];
      @(posedge CLK);
      da_wr <= 1'b0;
      @(negedge CLK);
      exp_pcm = pcm_of(r[8], r[9], r[7:0]);
      assert (pcm_out === exp_pcm) else begin
        $display("ERR pcm_out exp %h got %h", exp_pcm, pcm_out);
        errors++;
      end
    end
    report("dac", e0);

    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      settle_irq();
      pick_n(lo[k], hi[k], n);
      write_n(n);
      tone_ie <= 1'b1;
      repeat (2) begin
        base = load_cnt;
        wait_loads(base + 1);
        assert (last_vec === exp_vec[k]) else begin
          $display("ERR int_vec exp %h got %h for N %h", exp_vec[k], last_vec, n);
          errors++;
        end
        pulse_ack();
      end
    end
    report("vector", e0);

    e0 = errors;
    settle_irq();
    pick_n(64, 255, n);
    write_n(n);
    tone_ie <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      base = load_cnt;
      wait_loads(base + 1);
      t[k] = last_load_cyc;
      pulse_ack();
    end
    for (int k = 2; k < 4; k++) begin
      assert (t[k] - t[k-1] == int'(n) * 8) else begin
        $display("ERR load_period exp %h got %h", int'(n) * 8, t[k] - t[k-1]);
        errors++;
      end
    end
    report("period", e0);

    e0 = errors;
    settle_irq();
    pick_n(0, 7, n);
    write_n(n);
    tone_ie <= 1'b1;
    base = load_cnt;
    repeat (300 * 8) @(posedge CLK);
    settle_irq();
    pick_n(8, 63, n);
    write_n(n);
    repeat (300 * 8) @(posedge CLK);
    assert (load_cnt == base) else begin
      $display("irq_load pulsed %0d times with no interrupt enabled", load_cnt - base);
      errors++;
    end
    report("quiet", e0);

    e0 = errors;
    settle_irq();
    pick_n(16, 31, n);
    write_n(n);
    tone_ie <= 1'b1;
    base = load_cnt;
    wait_loads(base + 1);
    repeat (300 * 8) begin
      @(negedge CLK);
      assert (irq_active === 1'b1) else begin
        $display("ERR irq_active exp 1 got %h while unacknowledged", irq_active);
        errors++;
      end
    end
    assert (load_cnt == base + 1) else begin
      $display("a second irq_load came while the interrupt was active");
      errors++;
    end
    pulse_ack();
    @(negedge CLK);
    assert (irq_active === 1'b0) else begin
      $display("ERR irq_active exp 0 got %h after int_ack", irq_active);
      errors++;
    end
    wait_loads(base + 2);
    report("single", e0);

    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tests/upd1771_snd_props.sv */
module upd1771_snd_props
  import upd1771_snd_pkg::*;
(
  input logic CLK,
  input logic arst_n,
  input logic tick,
  input logic irq_load,
  input logic irq_active
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] since_tick;  // cycles since the last tick

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      since_tick <= '0;
    end else if (tick) begin
      since_tick <= '0;
    end else begin
      since_tick <= since_tick + 8'd1;
    end
  end

  ////////////////////
  // properties
  ////////////////////

  // load lands on the last cycle of a machine tick
  load_on_tick: assert property (@(posedge CLK) disable iff (!arst_n)
    irq_load |-> (since_tick == 8'(TICK_DIV - 1)))
    else $error("irq_load outside a tick");

  // a load never follows straight on from an active interrupt
  no_load_when_active: assert property (@(posedge CLK) disable iff (!arst_n)
    irq_load |-> !$past(irq_active))
    else $error("irq_load while already active");

  tick_period: assert property (@(posedge CLK) disable iff (!arst_n)
    tick == (since_tick == 8'(TICK_DIV - 1)))
    else $error("tick spacing differs from TICK_DIV");

endmodule

bind tone_irq upd1771_snd_props props_i (
  .CLK        (CLK),
  .arst_n     (arst_n),
  .tick       (tick),
  .irq_load   (irq_load),
  .irq_active (irq_active)
);
